//--- common/mpu_consts.svh
`ifndef MPU_CONSTS_SVH
`define MPU_CONSTS_SVH

// Memory address and stack pointer width
`define MPU_ADDR_W 16

// Region table geometry
`define MPU_MAPS 9
`define MPU_ROWS 4
`define MPU_ID_W 4

// CSR address of map 0, row 0
`define MPU_CSR_BASE 12'h400

// Lowest address of the stack area
`define MPU_STACK_TOP 1280

// Interrupt priority levels, one stack record each
`define MPU_PRIO_W 2
`define MPU_PRIO_LEVELS 4

`endif

//--- common/csr_pkg.sv
`default_nettype none

package csr_pkg;

    typedef logic [11:0] csr_addr_t;

    // Read-modify-write flavours of a CSR access
    typedef enum logic [1:0] {
        CSR_WRITE = 2'd0,
        CSR_SET   = 2'd1,
        CSR_CLEAR = 2'd2
    } csr_op_t;

    // Single-cycle command, valid when enable is high
    typedef struct packed {
        logic        enable;
        csr_addr_t   addr;
        csr_op_t     op;
        logic [31:0] data;
    } csr_cmd_t;

endpackage

`default_nettype wire

//--- common/mpu_pkg.sv
`default_nettype none

`include "mpu_consts.svh"

package mpu_pkg;

    typedef enum logic [6:0] {
        MPU_OP_LOAD  = 7'b0000011,
        MPU_OP_STORE = 7'b0100011
    } mpu_op_t;

    // One permission region, as laid out in its CSR word
    typedef struct packed {
        logic [17:0] base;
        logic [11:0] length;
        logic        write_en;
        logic        read_en;
    } mpu_region_t;

    // CSR data seen either as a plain word or as a region
    typedef union packed {
        logic [31:0] raw;
        mpu_region_t region;
    } mpu_region_word_u;

    // Op is kept as a raw opcode so any instruction can be presented
    typedef struct packed {
        logic [`MPU_ADDR_W-1:0] addr;
        logic [6:0]             op;
    } mpu_access_t;

endpackage

`default_nettype wire

//--- mpu/mpu_region_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "mpu_consts.svh"

module mpu_region_table
    import csr_pkg::*, mpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  csr_cmd_t             csr,
    input  logic [`MPU_ID_W-1:0] id,
    output mpu_region_t          current_map [`MPU_ROWS]
);

    localparam int ENTRIES = `MPU_MAPS * `MPU_ROWS;
    localparam int IDX_W   = $clog2(ENTRIES);

    mpu_region_t entries [ENTRIES];

    logic [11:0]      offset;
    logic [IDX_W-1:0] idx;
    logic             hit;

    mpu_region_word_u old_word;
    mpu_region_word_u new_word;

    // Map the CSR address onto a flat entry index
    assign offset = csr.addr - `MPU_CSR_BASE;
    assign idx    = offset[IDX_W-1:0];
    assign hit    = csr.enable && (csr.addr >= `MPU_CSR_BASE)
                    && (offset < 12'(ENTRIES));

    always_comb begin
        old_word.region = hit ? entries[idx] : '0;
        case (csr.op)
            CSR_SET:   new_word.raw = old_word.raw | csr.data;
            CSR_CLEAR: new_word.raw = old_word.raw & ~csr.data;
            default:   new_word.raw = csr.data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            entries <= '{default: '0};
        end else if (hit) begin
            entries[idx] <= new_word.region;
        end
    end

    // Current task's rows, registered; unknown ids get empty rows
    always_ff @(posedge clk) begin
        if (reset) begin
            current_map <= '{default: '0};
        end else begin
            for (int r = 0; r < `MPU_ROWS; r++) begin
                if (int'(id) < `MPU_MAPS) begin
                    current_map[r] <= entries[int'(id) * `MPU_ROWS + r];
                end else begin
                    current_map[r] <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- mpu/mpu_stack_frame.sv
`timescale 1ns/1ps
`default_nettype none

`include "mpu_consts.svh"

module mpu_stack_frame (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`MPU_ADDR_W-1:0] sp,
    input  logic [`MPU_PRIO_W-1:0] prio,
    output logic [`MPU_ADDR_W-1:0] frame_top
);

    // sp at the moment each priority level was entered
    logic [`MPU_ADDR_W-1:0] records [`MPU_PRIO_LEVELS];
    logic [`MPU_PRIO_W-1:0] prev_prio;

    always_ff @(posedge clk) begin
        if (reset) begin
            records   <= '{default: '0};
            prev_prio <= '0;
            frame_top <= '0;
        end else begin
            if (prio != prev_prio) begin
                records[prio] <= sp;
            end
            prev_prio <= prio;
            // Picks up a fresh capture one cycle later
            frame_top <= records[prio];
        end
    end

endmodule

`default_nettype wire

//--- mpu/mpu_access_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "mpu_consts.svh"

module mpu_access_check
    import mpu_pkg::*;
(
    input  logic                   reset,
    input  mpu_access_t            access,
    input  mpu_region_t            current_map [`MPU_ROWS],
    input  logic [`MPU_ADDR_W-1:0] frame_top,
    output logic                   fault
);

    logic [18:0]           addr_ext;
    logic [`MPU_ROWS-1:0]  row_read;
    logic [`MPU_ROWS-1:0]  row_write;
    logic                  is_load;
    logic                  is_store;
    logic                  granted;
    logic                  outside_stack;

    assign addr_ext = 19'(access.addr);

    for (genvar r = 0; r < `MPU_ROWS; r++) begin : g_row
        logic [18:0] lo;
        logic [18:0] hi;
        logic        row_hit;

        // One extra bit so base plus length never wraps
        assign lo      = {1'b0, current_map[r].base};
        assign hi      = lo + 19'(current_map[r].length);
        assign row_hit = (addr_ext >= lo) && (addr_ext <= hi);

        assign row_read[r]  = row_hit && current_map[r].read_en;
        assign row_write[r] = row_hit && current_map[r].write_en;
    end

    assign is_load  = (access.op == MPU_OP_LOAD);
    assign is_store = (access.op == MPU_OP_STORE);

    assign granted = (is_load && |row_read) || (is_store && |row_write);

    // Stack frame runs from the stack floor up to the captured sp
    assign outside_stack = (access.addr > frame_top)
                           || (access.addr < `MPU_ADDR_W'(`MPU_STACK_TOP));

    assign fault = !reset && (is_load || is_store) && outside_stack && !granted;

endmodule

`default_nettype wire

//--- rtl/mpu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mpu_consts.svh"

module mpu_top
    import csr_pkg::*, mpu_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  csr_cmd_t               csr,
    input  logic [`MPU_ID_W-1:0]   id,
    input  logic [`MPU_ADDR_W-1:0] sp,
    input  logic [`MPU_PRIO_W-1:0] prio,
    input  mpu_access_t            access,
    output logic                   fault
);

    mpu_region_t            current_map [`MPU_ROWS];
    logic [`MPU_ADDR_W-1:0] frame_top;

    // CSR-programmed regions of the running task
    mpu_region_table u_region_table (
        .clk         (clk),
        .reset       (reset),
        .csr         (csr),
        .id          (id),
        .current_map (current_map)
    );

    mpu_stack_frame u_stack_frame (
        .clk       (clk),
        .reset     (reset),
        .sp        (sp),
        .prio      (prio),
        .frame_top (frame_top)
    );

    // Fault is combinational from access
    mpu_access_check u_access_check (
        .reset       (reset),
        .access      (access),
        .current_map (current_map),
        .frame_top   (frame_top),
        .fault       (fault)
    );

endmodule

`default_nettype wire

//--- test/tb_mpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "mpu_consts.svh"

module tb_mpu
    import csr_pkg::*, mpu_pkg::*;
();

    // One line of the stimulus file
    typedef struct packed {
        int          test_num;
        logic [63:0] kind;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [7:0]  exp_fault;
    } step_t;

    logic                   clk = 1'b0;
    logic                   reset;
    csr_cmd_t               csr;
    logic [`MPU_ID_W-1:0]   id;
    logic [`MPU_ADDR_W-1:0] sp;
    logic [`MPU_PRIO_W-1:0] prio;
    mpu_access_t            access;
    logic                   fault;

    step_t steps [$];
    int    cycle_count = 0;
    int    cycle_limit = 0;
    int    error_count = 0;
    int    check_count = 0;
    int    test_errors = 0;
    int    tests_run   = 0;
    int    cur_test    = 0;
    int    step_idx    = 0;

    mpu_top u_dut (
        .clk    (clk),
        .reset  (reset),
        .csr    (csr),
        .id     (id),
        .sp     (sp),
        .prio   (prio),
        .access (access),
        .fault  (fault)
    );

    always #4 clk = ~clk;

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("mismatch %s: got %h expected %h (test %0d, step %0d)",
                     name, actual, expected, cur_test, step_idx);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic load_steps();
        int          fd;
        int          n;
        int          tnum;
        string       line;
        logic [63:0] kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [7:0]  ef;
        step_t       s;
        fd = $fopen("test/mpu_input.txt", "r");
        if (fd == 0) begin
            $display("error: could not open test/mpu_input.txt");
            error_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                // Skip comments and blank lines
                if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") begin
                    continue;
                end
                n = $sscanf(line, "%d %s %h %h %h %s", tnum, kind, a, b, c, ef);
                if (n != 6) begin
                    $display("error: malformed stimulus line: %s", line);
                    error_count++;
                end else begin
                    s.test_num  = tnum;
                    s.kind      = kind;
                    s.f1        = a;
                    s.f2        = b;
                    s.f3        = c;
                    s.exp_fault = ef;
                    steps.push_back(s);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_step(input step_t s);
        csr_cmd_t    cmd;
        mpu_access_t acc;
        if (s.kind == "csr") begin
            cmd.enable = 1'b1;
            cmd.addr   = s.f2[11:0];
            cmd.op     = csr_op_t'(s.f1[1:0]);
            cmd.data   = s.f3;
            @(posedge clk);
            csr <= cmd;
            @(posedge clk);
            csr.enable <= 1'b0;
            repeat (2) @(posedge clk);
        end else if (s.kind == "context") begin
            @(posedge clk);
            id   <= s.f1[`MPU_ID_W-1:0];
            sp   <= s.f2[`MPU_ADDR_W-1:0];
            prio <= s.f3[`MPU_PRIO_W-1:0];
            repeat (3) @(posedge clk);
        end else if (s.kind == "access") begin
            acc.op   = s.f1[6:0];
            acc.addr = s.f2[`MPU_ADDR_W-1:0];
            @(posedge clk);
            access <= acc;
            @(posedge clk);
            // Sample away from the edge so fault has settled
            @(negedge clk);
            if (s.exp_fault != "x") begin
                compare("fault", 32'(fault), 32'(s.exp_fault == "1"));
            end
        end else begin
            $display("error: unknown step kind at step %0d", step_idx);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic report_test(input int num);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d: ok", num);
        end else begin
            $display("test %0d: failed with %0d errors", num, test_errors);
        end
    endtask

    // Run length guard
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("error: run did not finish within %0d cycles", cycle_limit);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        reset  = 1'b1;
        csr    = '0;
        id     = '0;
        sp     = '0;
        prio   = '0;
        access = '{addr: 16'h0100, op: MPU_OP_STORE};
        load_steps();
        cycle_limit = steps.size() * 5 + 50;
        cur_test    = 1;

        // Store below the stack floor must not fault while in reset
        repeat (5) @(posedge clk);
        @(negedge clk);
        compare("fault", 32'(fault), 32'h0);
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        foreach (steps[i]) begin
            step_idx = i;
            if (steps[i].test_num != cur_test) begin
                report_test(cur_test);
                cur_test    = steps[i].test_num;
                test_errors = 0;
            end
            run_step(steps[i]);
        end
        report_test(cur_test);

        $display("tests: %0d, checks: %0d, errors: %0d",
                 tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/mpu_input.txt
# test kind f1 f2 f3 fault   (fields in hex, fault x means no check)
# csr: op addr data | context: id sp prio | access: opcode addr unused
1 context 0 0000 0 x
1 access 23 0100 0 1
1 access 03 04ff 0 1
2 context 0 0600 1 x
2 access 03 0500 0 0
2 access 03 0600 0 0
2 access 23 0580 0 0
2 access 23 0601 0 1
2 context 0 0550 2 x
2 access 23 0580 0 1
3 csr 0 400 00400081 x
3 access 03 0100 0 0
3 access 03 0120 0 0
3 access 23 0110 0 1
3 access 03 0121 0 1
3 access 03 00ff 0 1
4 csr 1 400 00000002 x
4 access 23 0110 0 0
4 access 03 0110 0 0
4 csr 2 400 00000001 x
4 access 03 0110 0 1
4 access 23 0120 0 0
4 access 23 0121 0 1
5 csr 0 406 00800043 x
5 access 03 0208 0 1
5 context 1 0550 2 x
5 access 23 0208 0 0
5 access 03 0210 0 0
5 access 23 0110 0 1
5 context 9 0550 2 x
5 access 03 0208 0 1
5 access 23 0110 0 1
5 access 03 0520 0 0
5 context f 0550 2 x
5 access 23 0200 0 1
5 context 0 0550 2 x
5 access 23 0110 0 0
6 access 13 0000 0 0
6 access 33 ffff 0 0
6 access 6f 0800 0 0
6 access 00 0100 0 0
6 access 03 ffff 0 1

//--- all.f
+incdir+common
common/csr_pkg.sv
common/mpu_pkg.sv
mpu/mpu_region_table.sv
mpu/mpu_stack_frame.sv
mpu/mpu_access_check.sv
rtl/mpu_top.sv
test/tb_mpu.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the MPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mpu -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_mpu)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "PASS: all tests" <<< "$output"; then
    exit 0
fi
exit 1
